//--- files.f
+incdir+.
i3c_regf_pkg.sv
i3c_regf_access.sv
i3c_regf_store.sv
i3c_cmd_desc_unpack.sv
i3c_regf_top.sv
i3c_regf_assert.sv
i3c_regf_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the I3C register file testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module i3c_regf_tb -o i3c_regf_sim

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/i3c_regf_sim +verilator+error+limit+100 | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
  echo "Simulation result: passed"
  exit 0
else
  echo "Simulation result: failed"
  exit 1
fi

//--- i3c_regf_tb.sv
//////////////////////////////
// I3C register file testbench
// Byte model with the reset table, LCG stimulus and
// self-checking compares against the DUT
//////////////////////////////
`timescale 1ns/1ps

`include "i3c_regf_params.svh"

module i3c_regf_tb
  import i3c_regf_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 32;
  // Twice the reset, 40 default reads, random write/read pairs and the directed tests
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 40 * 3 + NUM_RANDOM * 5 + 200);

  // Reset table as {address, byte}
  localparam logic [16:0] DEF_TABLE [40] = '{
    {9'd0,   8'hA8}, {9'd1,   8'h02}, {9'd2,   8'h01}, {9'd3,   8'h02}, {9'd4,   8'h06},
    {9'd35,  8'h02}, {9'd46,  8'hFC}, {9'd47,  8'hFD}, {9'd48,  8'h53}, {9'd49,  8'h07},
    {9'd50,  8'h20}, {9'd101, 8'h01}, {9'd102, 8'h03}, {9'd103, 8'h81}, {9'd104, 8'h01},
    {9'd381, 8'h94}, {9'd382, 8'h91}, {9'd383, 8'h02}, {9'd384, 8'h95}, {9'd386, 8'h02},
    {9'd387, 8'h90}, {9'd388, 8'h02}, {9'd389, 8'h91}, {9'd390, 8'h02}, {9'd392, 8'h0B},
    {9'd393, 8'h02}, {9'd394, 8'h03}, {9'd395, 8'h04}, {9'd396, 8'h05}, {9'd397, 8'h08},
    {9'd402, 8'h03}, {9'd403, 8'h01}, {9'd404, 8'h08}, {9'd405, 8'h07}, {9'd406, 8'h09},
    {9'd407, 8'h01}, {9'd409, 8'h00}, {9'd450, 8'h81}, {9'd451, 8'h8F}, {9'd453, 8'h18}
  };

  logic                   clk;
  logic                   rst_n;
  logic                   rd_en;
  logic                   wr_en;
  logic [`REGF_ADDR-1:0]  addr;
  logic [`REGF_WIDTH-1:0] data_wr;
  logic                   desc_dummy;
  logic [`REGF_WIDTH-1:0] o_regf_data_rd;
  logic [`REGF_WIDTH-1:0] o_regf_num_frames;
  logic                   o_ser_rx_tx;
  logic [`REGF_WIDTH-1:0] o_regf_ibi_cfg;
  logic [`REGF_WIDTH-1:0] o_regf_ibi_payload_size;
  logic [`REGF_WIDTH-1:0] o_ibi_tgt_address;
  logic [`REGF_WIDTH-1:0] o_crh_crhdly;
  logic [`REGF_WIDTH-1:0] o_crh_getstatus_data;
  logic [`REGF_WIDTH-1:0] o_crh_crcap2;
  logic [`REGF_WIDTH-1:0] o_crh_precr;
  logic [`REGF_WIDTH-1:0] o_crh_cfg_reg;
  logic [`REGF_WIDTH-1:0] o_crh_tgts_count;
  logic [2:0]             o_regf_hj_cfg;
  logic                   o_regf_hj_support;
  cmd_desc_t              o_cmd_desc;

  logic [`REGF_WIDTH-1:0] model_mem [`REGF_DEPTH];   // Expected array contents
  logic [31:0]            lcg_state;
  int                     errors = 0;
  int                     checks = 0;
  int                     test_count = 0;
  int                     cycles = 0;

  i3c_regf_top i3c_regf_top_i (
    .i_regf_clk              (clk),
    .i_regf_rst_n            (rst_n),
    .i_regf_rd_en            (rd_en),
    .i_regf_wr_en            (wr_en),
    .i_regf_addr             (addr),
    .i_regf_data_wr          (data_wr),
    .i_desc_dummy            (desc_dummy),
    .o_regf_data_rd          (o_regf_data_rd),
    .o_regf_num_frames       (o_regf_num_frames),
    .o_ser_rx_tx             (o_ser_rx_tx),
    .o_regf_ibi_cfg          (o_regf_ibi_cfg),
    .o_regf_ibi_payload_size (o_regf_ibi_payload_size),
    .o_ibi_tgt_address       (o_ibi_tgt_address),
    .o_crh_crhdly            (o_crh_crhdly),
    .o_crh_getstatus_data    (o_crh_getstatus_data),
    .o_crh_crcap2            (o_crh_crcap2),
    .o_crh_precr             (o_crh_precr),
    .o_crh_cfg_reg           (o_crh_cfg_reg),
    .o_crh_tgts_count        (o_crh_tgts_count),
    .o_regf_hj_cfg           (o_regf_hj_cfg),
    .o_regf_hj_support       (o_regf_hj_support),
    .o_cmd_desc              (o_cmd_desc)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////// Reference model

  function automatic logic [7:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];   // Middle bits since the low ones cycle too fast
  endfunction

  // ENHJ when hot-join is both supported and enabled
  function automatic logic hj_expected(input logic [7:0] crcap1, input logic [7:0] hj_cfg);
    return crcap1[0] & hj_cfg[1];
  endfunction

  function automatic cmd_desc_t desc_expected(input int base);
    logic [31:0] dw0;
    logic [31:0] dw1;
    cmd_desc_t   d;
    dw0 = {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
    dw1 = {model_mem[base+7], model_mem[base+6], model_mem[base+5], model_mem[base+4]};
    d.data_len  = dw1[31:16];
    d.cmd_attr  = dw0[2:0];
    d.tid       = dw0[6:3];
    d.ccc_cmd   = dw0[14:7];
    d.cp        = dw0[15];
    d.dev_index = dw0[20:16];
    d.dtt       = dw0[25:23];
    d.mode      = dw0[28:26];
    d.rnw       = dw0[29];
    d.wroc      = dw0[30];
    d.toc       = dw0[31];
    return d;
  endfunction

  // Hot-join bits and the serializer zero byte
  task automatic apply_model_rules();
    logic hj;
    hj = hj_expected(model_mem[`REGF_CRCAP1], model_mem[`REGF_HJ_CFG]);
    model_mem[`REGF_ENEC_BYTE][3]  = hj;
    model_mem[`REGF_DISEC_BYTE][3] = ~hj;
    model_mem[(desc_dummy ? `REGF_DESC_DUMMY : `REGF_DESC_NORMAL) - 1] = '0;
  endtask

  task automatic load_model_defaults();
    for (int i = 0; i < `REGF_DEPTH; i++)
    begin
      model_mem[i] = '0;
    end
    for (int i = 0; i < 40; i++)
    begin
      model_mem[DEF_TABLE[i][16:8]] = DEF_TABLE[i][7:0];
    end
    apply_model_rules();
  endtask

  ////////////////////////////// Host access and checks

  task automatic compare_values(input string name, input logic [63:0] actual,
                                input logic [63:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  // Called and returns on a falling edge
  task automatic write_byte(input int a, input logic [7:0] d);
    wr_en   = 1'b1;
    addr    = 9'(a);
    data_wr = d;
    @(negedge clk);
    wr_en = 1'b0;
    model_mem[a] = d;
    apply_model_rules();
  endtask

  task automatic read_check(input int a);
    rd_en = 1'b1;
    addr  = 9'(a);
    @(negedge clk);
    rd_en = 1'b0;
    @(negedge clk);                                  // Data is out 2 edges after the strobe
    compare_values($sformatf("o_regf_data_rd @%0d", a), o_regf_data_rd, model_mem[a]);
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    $display("Test %0d %s: %s", test_count, name,
             (errors == errs_before) ? "ok" : "mismatches");
  endtask

  ////////////////////////////// Stimulus

  initial
  begin
    int         mark;
    int         a;
    logic [7:0] cap;
    logic [7:0] cfg;
    lcg_state  = 32'd88;
    rst_n      = 1'b0;
    rd_en      = 1'b0;
    wr_en      = 1'b0;
    addr       = '0;
    data_wr    = '0;
    desc_dummy = 1'b0;
    load_model_defaults();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Reset defaults
    mark = errors;
    compare_values("o_regf_data_rd", o_regf_data_rd, 8'h00);
    compare_values("o_cmd_desc", o_cmd_desc, 64'h0);
    for (int i = 0; i < 40; i++)
    begin
      read_check(DEF_TABLE[i][16:8]);
    end
    end_test("reset defaults", mark);

    // Random write and read back below every forced byte
    mark = errors;
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      a = {lcg_next(), lcg_next()} % 400;
      write_byte(a, lcg_next());
      read_check(a);
    end
    end_test("random write/read", mark);

    // Both strobes together
    mark = errors;
    write_byte(3, ~model_mem[2]);        // Read data differs from the target byte
    read_check(3);
    rd_en   = 1'b1;
    wr_en   = 1'b1;
    addr    = 9'd2;
    data_wr = ~model_mem[2];
    @(negedge clk);
    rd_en = 1'b0;
    wr_en = 1'b0;
    repeat (2) @(negedge clk);
    compare_values("o_regf_data_rd after conflict", o_regf_data_rd, model_mem[3]);
    read_check(2);
    end_test("conflict", mark);

    // Descriptor on the normal then the dummy base
    mark = errors;
    write_byte(`REGF_DESC_NORMAL - 1, lcg_next() | 8'h01);   // Zero byte ignores host writes
    read_check(`REGF_DESC_NORMAL - 1);
    for (int k = 0; k < 8; k++)
    begin
      write_byte(`REGF_DESC_NORMAL + k, lcg_next());
    end
    repeat (2) @(negedge clk);
    compare_values("o_cmd_desc normal", o_cmd_desc, desc_expected(`REGF_DESC_NORMAL));
    desc_dummy = 1'b1;
    apply_model_rules();
    repeat (2) @(negedge clk);
    compare_values("o_cmd_desc dummy", o_cmd_desc, desc_expected(`REGF_DESC_DUMMY));
    desc_dummy = 1'b0;
    apply_model_rules();
    repeat (2) @(negedge clk);
    end_test("descriptor", mark);

    // Hot-join rule over all support/enable pairs
    mark = errors;
    for (int c = 0; c < 4; c++)
    begin
      cap    = lcg_next();
      cfg    = lcg_next();
      cap[0] = c[0];
      cfg[1] = c[1];
      write_byte(`REGF_ENEC_BYTE, lcg_next());    // Host bit 3 is overridden
      write_byte(`REGF_DISEC_BYTE, lcg_next());
      write_byte(`REGF_CRCAP1, cap);
      write_byte(`REGF_HJ_CFG, cfg);
      @(negedge clk);                    // ENHJ and DISHJ follow one edge later
      read_check(`REGF_ENEC_BYTE);
      read_check(`REGF_DISEC_BYTE);
      compare_values("o_regf_hj_cfg", o_regf_hj_cfg, cfg[2:0]);
      compare_values("o_regf_hj_support", o_regf_hj_support, cap[0]);
    end
    end_test("hot-join", mark);

    // Status copies of the written bytes
    mark = errors;
    write_byte(`REGF_NUM_FRAMES, lcg_next());
    write_byte(`REGF_TGT_ADDR, lcg_next());
    write_byte(`REGF_IBI_CFG, lcg_next());
    write_byte(`REGF_IBI_PAYLOAD, lcg_next());
    write_byte(`REGF_ARB, lcg_next());
    write_byte(`REGF_CRHDLY, lcg_next());
    write_byte(`REGF_GETSTATUS_LSB, lcg_next());
    write_byte(`REGF_CRCAP2, lcg_next());
    write_byte(`REGF_PRECR, lcg_next());
    write_byte(`REGF_CRH_CFG, lcg_next());
    write_byte(`REGF_TGTS_COUNT, lcg_next());
    repeat (2) @(negedge clk);
    compare_values("o_regf_num_frames", o_regf_num_frames, model_mem[`REGF_NUM_FRAMES]);
    compare_values("o_ser_rx_tx", o_ser_rx_tx, model_mem[`REGF_TGT_ADDR][0]);
    compare_values("o_regf_ibi_cfg", o_regf_ibi_cfg, model_mem[`REGF_IBI_CFG]);
    compare_values("o_regf_ibi_payload_size", o_regf_ibi_payload_size,
                   model_mem[`REGF_IBI_PAYLOAD]);
    compare_values("o_ibi_tgt_address", o_ibi_tgt_address, model_mem[`REGF_ARB]);
    compare_values("o_crh_crhdly", o_crh_crhdly, model_mem[`REGF_CRHDLY]);
    compare_values("o_crh_getstatus_data", o_crh_getstatus_data,
                   model_mem[`REGF_GETSTATUS_LSB]);
    compare_values("o_crh_crcap2", o_crh_crcap2, model_mem[`REGF_CRCAP2]);
    compare_values("o_crh_precr", o_crh_precr, model_mem[`REGF_PRECR]);
    compare_values("o_crh_cfg_reg", o_crh_cfg_reg, model_mem[`REGF_CRH_CFG]);
    compare_values("o_crh_tgts_count", o_crh_tgts_count, model_mem[`REGF_TGTS_COUNT]);
    end_test("status outputs", mark);

    // Assertion failures count as errors too
    errors += i3c_regf_top_i.i3c_regf_store_i.i3c_regf_assert_i.fail_count;
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, checks, errors);
    if (errors == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- i3c_regf_assert.sv
//////////////////////////////
// I3C register file assertions
// Conflict, hot-join pair, zero byte and read data
//////////////////////////////
`timescale 1ns/1ps

`include "i3c_regf_params.svh"

module i3c_regf_assert
  import i3c_regf_pkg::*;
(
  input logic                   i_regf_clk,
  input logic                   i_regf_rst_n,
  input regf_req_t              i_req,
  input logic                   i_desc_dummy,
  input logic [`REGF_ADDR-1:0]  i_zero_addr,                 // Byte below the active base
  input logic [`REGF_WIDTH-1:0] i_regf_mem [`REGF_DEPTH],
  input logic [`REGF_WIDTH-1:0] i_regf_data_rd
);

  int fail_count = 0;

  // Addressed byte survives a conflicting request
  conflict_keeps_byte: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    (i_req.op == OP_CONFLICT) |=>
      (i_regf_mem[$past(i_req.addr)] == $past(i_regf_mem[i_req.addr])))
  else
  begin
    $error("OP_CONFLICT changed the addressed byte");
    fail_count++;
  end

  // ENHJ follows support and enable one edge late, DISHJ mirrors it
  hj_pair_inverse: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    $past(i_regf_rst_n) |->
      ((i_regf_mem[`REGF_ENEC_BYTE][3] ==
        $past(i_regf_mem[`REGF_CRCAP1][0] & i_regf_mem[`REGF_HJ_CFG][1])) &&
       (i_regf_mem[`REGF_ENEC_BYTE][3] != i_regf_mem[`REGF_DISEC_BYTE][3])))
  else
  begin
    $error("ENHJ and DISHJ do not follow the hot-join rule");
    fail_count++;
  end

  // Only once the base has been stable for an edge
  zero_byte_clear: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    $stable(i_desc_dummy) |-> (i_regf_mem[i_zero_addr] == '0))
  else
  begin
    $error("Serializer zero byte is not zero");
    fail_count++;
  end

  read_data_known: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    !$isunknown(i_regf_data_rd))
  else
  begin
    $error("Read data is unknown");
    fail_count++;
  end

endmodule

bind i3c_regf_store i3c_regf_assert i3c_regf_assert_i (
  .i_regf_clk     (i_regf_clk),
  .i_regf_rst_n   (i_regf_rst_n),
  .i_req          (i_req),
  .i_desc_dummy   (i_desc_dummy),
  .i_zero_addr    (zero_addr),
  .i_regf_mem     (regf_mem),
  .i_regf_data_rd (o_regf_data_rd)
);

//--- i3c_regf_top.sv
//////////////////////////////
// I3C register file top
// Access stage, byte store and descriptor unpacker
//////////////////////////////
`timescale 1ns/1ps

`include "i3c_regf_params.svh"

module i3c_regf_top
  import i3c_regf_pkg::*;
(
  input  logic                   i_regf_clk,
  input  logic                   i_regf_rst_n,
  input  logic                   i_regf_rd_en,
  input  logic                   i_regf_wr_en,
  input  logic [`REGF_ADDR-1:0]  i_regf_addr,
  input  logic [`REGF_WIDTH-1:0] i_regf_data_wr,
  input  logic                   i_desc_dummy,
  output logic [`REGF_WIDTH-1:0] o_regf_data_rd,           // 2 edges after strobe
  output logic [`REGF_WIDTH-1:0] o_regf_num_frames,
  output logic                   o_ser_rx_tx,
  output logic [`REGF_WIDTH-1:0] o_regf_ibi_cfg,
  output logic [`REGF_WIDTH-1:0] o_regf_ibi_payload_size,
  output logic [`REGF_WIDTH-1:0] o_ibi_tgt_address,
  output logic [`REGF_WIDTH-1:0] o_crh_crhdly,
  output logic [`REGF_WIDTH-1:0] o_crh_getstatus_data,
  output logic [`REGF_WIDTH-1:0] o_crh_crcap2,
  output logic [`REGF_WIDTH-1:0] o_crh_precr,
  output logic [`REGF_WIDTH-1:0] o_crh_cfg_reg,
  output logic [`REGF_WIDTH-1:0] o_crh_tgts_count,
  output logic [2:0]             o_regf_hj_cfg,
  output logic                   o_regf_hj_support,
  output cmd_desc_t              o_cmd_desc
);

  regf_req_t   req;           // Access stage to store
  logic [63:0] desc_window;   // Store to unpacker

  i3c_regf_access i3c_regf_access_i (
    .i_regf_clk     (i_regf_clk),
    .i_regf_rst_n   (i_regf_rst_n),
    .i_regf_rd_en   (i_regf_rd_en),
    .i_regf_wr_en   (i_regf_wr_en),
    .i_regf_addr    (i_regf_addr),
    .i_regf_data_wr (i_regf_data_wr),
    .o_req          (req)
  );

  i3c_regf_store i3c_regf_store_i (
    .i_regf_clk              (i_regf_clk),
    .i_regf_rst_n            (i_regf_rst_n),
    .i_req                   (req),
    .i_desc_dummy            (i_desc_dummy),
    .o_desc_window           (desc_window),
    .o_regf_data_rd          (o_regf_data_rd),
    .o_regf_num_frames       (o_regf_num_frames),
    .o_ser_rx_tx             (o_ser_rx_tx),
    .o_regf_ibi_cfg          (o_regf_ibi_cfg),
    .o_regf_ibi_payload_size (o_regf_ibi_payload_size),
    .o_ibi_tgt_address       (o_ibi_tgt_address),
    .o_crh_crhdly            (o_crh_crhdly),
    .o_crh_getstatus_data    (o_crh_getstatus_data),
    .o_crh_crcap2            (o_crh_crcap2),
    .o_crh_precr             (o_crh_precr),
    .o_crh_cfg_reg           (o_crh_cfg_reg),
    .o_crh_tgts_count        (o_crh_tgts_count),
    .o_regf_hj_cfg           (o_regf_hj_cfg),
    .o_regf_hj_support       (o_regf_hj_support)
  );

  i3c_cmd_desc_unpack i3c_cmd_desc_unpack_i (
    .i_regf_clk    (i_regf_clk),
    .i_regf_rst_n  (i_regf_rst_n),
    .i_desc_window (desc_window),
    .o_cmd_desc    (o_cmd_desc)
  );

endmodule

//--- i3c_cmd_desc_unpack.sv
//////////////////////////////
// I3C command descriptor unpacker
// Slices the 8 byte descriptor window into
// registered command fields
//////////////////////////////
`timescale 1ns/1ps

`include "i3c_regf_params.svh"

module i3c_cmd_desc_unpack
  import i3c_regf_pkg::*;
(
  input  logic        i_regf_clk,
  input  logic        i_regf_rst_n,
  input  logic [63:0] i_desc_window,    // Bytes base..base+7, LSB first
  output cmd_desc_t   o_cmd_desc
);

  logic [31:0] dword0;
  logic [31:0] dword1;
  cmd_desc_t   desc_d;

  assign dword0 = i_desc_window[31:0];
  assign dword1 = i_desc_window[63:32];

  ////////////////////////////// Field map

  always_comb
  begin
    desc_d.data_len  = dword1[31:16];   // Low half of DWORD1 unused here
    desc_d.cmd_attr  = dword0[2:0];
    desc_d.tid       = dword0[6:3];
    desc_d.ccc_cmd   = dword0[14:7];
    desc_d.cp        = dword0[15];
    desc_d.dev_index = dword0[20:16];
    // Bits 22:21 reserved
    desc_d.dtt       = dword0[25:23];
    desc_d.mode      = dword0[28:26];
    desc_d.rnw       = dword0[29];
    desc_d.wroc      = dword0[30];
    desc_d.toc       = dword0[31];
  end

  ////////////////////////////// Output register

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_cmd_desc <= '0;
    end
    else
    begin
      o_cmd_desc <= desc_d;   // Tracks descriptor edits and base switches
    end
  end

endmodule

//--- i3c_regf_store.sv
//////////////////////////////
// I3C register file store
// 512 byte configuration array with reset table, host
// access, hot-join bit rule, serializer zero byte and
// the status registers for the controller blocks
//////////////////////////////
`timescale 1ns/1ps

`include "i3c_regf_params.svh"

module i3c_regf_store
  import i3c_regf_pkg::*;
(
  input  logic                   i_regf_clk,
  input  logic                   i_regf_rst_n,
  input  regf_req_t              i_req,                    // From access stage
  input  logic                   i_desc_dummy,             // Pick dummy descriptor
  output logic [63:0]            o_desc_window,            // 8 descriptor bytes
  output logic [`REGF_WIDTH-1:0] o_regf_data_rd,           // Held until next read
  // Status to frame counter, serializer and IBI
  output logic [`REGF_WIDTH-1:0] o_regf_num_frames,
  output logic                   o_ser_rx_tx,
  output logic [`REGF_WIDTH-1:0] o_regf_ibi_cfg,
  output logic [`REGF_WIDTH-1:0] o_regf_ibi_payload_size,
  output logic [`REGF_WIDTH-1:0] o_ibi_tgt_address,
  // Status to role handoff
  output logic [`REGF_WIDTH-1:0] o_crh_crhdly,
  output logic [`REGF_WIDTH-1:0] o_crh_getstatus_data,
  output logic [`REGF_WIDTH-1:0] o_crh_crcap2,
  output logic [`REGF_WIDTH-1:0] o_crh_precr,
  output logic [`REGF_WIDTH-1:0] o_crh_cfg_reg,
  output logic [`REGF_WIDTH-1:0] o_crh_tgts_count,
  // Hot-join
  output logic [2:0]             o_regf_hj_cfg,
  output logic                   o_regf_hj_support
);

  logic [`REGF_WIDTH-1:0] regf_mem [`REGF_DEPTH];
  logic [`REGF_ADDR-1:0]  desc_base;
  logic [`REGF_ADDR-1:0]  zero_addr;
  logic                   hj_enable;

  ////////////////////////////// Reset table

  // Anything not listed resets to zero
  function automatic logic [`REGF_WIDTH-1:0] regf_default(input logic [`REGF_ADDR-1:0] addr);
    logic [`REGF_WIDTH-1:0] val;
    val = '0;
    case (addr)
      `REGF_TGT_ADDR:      val = 8'hA8;   // Write direction
      `REGF_NUM_FRAMES:    val = 8'h02;
      2:                   val = 8'h01;
      3:                   val = 8'h02;
      4:                   val = 8'h06;
      `REGF_TGTS_COUNT:    val = 8'h02;
      `REGF_BDCST:         val = 8'hFC;   // 7'h7E + W
      47:                  val = 8'hFD;   // 7'h7E + R
      `REGF_ARB:           val = 8'h53;
      49:                  val = 8'h07;   // ENTDAA
      50:                  val = 8'h20;   // ENTHDR0
      `REGF_IBI_CFG:       val = 8'h01;   // ACK with MDB only
      `REGF_IBI_PAYLOAD:   val = 8'h03;
      103:                 val = 8'h81;   // DISEC direct
      104:                 val = 8'h01;   // DISEC broadcast
      381:                 val = 8'h94;   // GETMXDS
      382:                 val = 8'h91;
      `REGF_CRHDLY:        val = 8'h02;
      384:                 val = 8'h95;   // GETCAPS
      `REGF_CRCAP2:        val = 8'h02;
      387:                 val = 8'h90;   // GETSTATUS
      `REGF_PRECR:         val = 8'h02;
      389:                 val = 8'h91;   // GETACCCR
      `REGF_GETSTATUS_LSB: val = 8'h02;
      392:                 val = 8'h0B;
      393:                 val = 8'h02;   // ENTAS0..3
      394:                 val = 8'h03;
      395:                 val = 8'h04;
      396:                 val = 8'h05;
      397:                 val = 8'h08;   // DEFTGTS
      403:                 val = 8'h01;   // DISEC CCC
      `REGF_ENEC_BYTE:     val = 8'h03;   // ENINT, ENCR, ENHJ clear since CRCAP1[0] = 0
      `REGF_DISEC_BYTE:    val = 8'h08;   // DISHJ set to match
      `REGF_HJ_CFG:        val = 8'h07;
      406:                 val = 8'h09;   // Hot-join and interrupts disabled
      `REGF_CRH_CFG:       val = 8'h01;
      `REGF_CRCAP1:        val = 8'h00;   // No hot-join support
      `REGF_DESC_DUMMY:    val = 8'h81;
      `REGF_DESC_DUMMY+1:  val = 8'h8F;
      `REGF_DESC_DUMMY+3:  val = 8'h18;
      default:             val = '0;
    endcase
    return val;
  endfunction

  ////////////////////////////// Descriptor window

  assign desc_base = i_desc_dummy ? `REGF_DESC_DUMMY : `REGF_DESC_NORMAL;
  assign zero_addr = desc_base - 1'b1;     // Sent in the serializer zeros phase

  always_comb
  begin
    for (int k = 0; k < 8; k++)
    begin
      o_desc_window[k*8 +: 8] = regf_mem[desc_base + 3'(k)];   // LSB first
    end
  end

  // Hot-join allowed only if supported and enabled
  assign hj_enable         = regf_mem[`REGF_CRCAP1][0] & regf_mem[`REGF_HJ_CFG][1];
  assign o_regf_hj_cfg     = regf_mem[`REGF_HJ_CFG][2:0];
  assign o_regf_hj_support = regf_mem[`REGF_CRCAP1][0];

  ////////////////////////////// Array and status

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      for (int i = 0; i < `REGF_DEPTH; i++)
      begin
        regf_mem[i] <= regf_default(i[`REGF_ADDR-1:0]);
      end
      o_regf_data_rd          <= '0;
      o_regf_num_frames       <= regf_default(`REGF_NUM_FRAMES);
      o_ser_rx_tx             <= 1'(regf_default(`REGF_TGT_ADDR));   // Direction bit
      o_regf_ibi_cfg          <= regf_default(`REGF_IBI_CFG);
      o_regf_ibi_payload_size <= regf_default(`REGF_IBI_PAYLOAD);
      o_ibi_tgt_address       <= regf_default(`REGF_ARB);
      o_crh_crhdly            <= regf_default(`REGF_CRHDLY);
      o_crh_getstatus_data    <= regf_default(`REGF_GETSTATUS_LSB);
      o_crh_crcap2            <= regf_default(`REGF_CRCAP2);
      o_crh_precr             <= regf_default(`REGF_PRECR);
      o_crh_cfg_reg           <= regf_default(`REGF_CRH_CFG);
      o_crh_tgts_count        <= regf_default(`REGF_TGTS_COUNT);
    end
    else
    begin
      // Status copies lag the array by one edge
      o_regf_num_frames       <= regf_mem[`REGF_NUM_FRAMES];
      o_ser_rx_tx             <= regf_mem[`REGF_TGT_ADDR][0];
      o_regf_ibi_cfg          <= regf_mem[`REGF_IBI_CFG];
      o_regf_ibi_payload_size <= regf_mem[`REGF_IBI_PAYLOAD];
      o_ibi_tgt_address       <= regf_mem[`REGF_ARB];
      o_crh_crhdly            <= regf_mem[`REGF_CRHDLY];
      o_crh_getstatus_data    <= regf_mem[`REGF_GETSTATUS_LSB];
      o_crh_crcap2            <= regf_mem[`REGF_CRCAP2];
      o_crh_precr             <= regf_mem[`REGF_PRECR];
      o_crh_cfg_reg           <= regf_mem[`REGF_CRH_CFG];
      o_crh_tgts_count        <= regf_mem[`REGF_TGTS_COUNT];

      case (i_req.op)
        OP_READ:  o_regf_data_rd         <= regf_mem[i_req.addr];
        OP_WRITE: regf_mem[i_req.addr]   <= i_req.wdata;
        default:  ;                                   // IDLE and CONFLICT do nothing
      endcase

      // Later assignments win over a host write to the same byte
      regf_mem[`REGF_ENEC_BYTE][3]  <= hj_enable;     // ENHJ
      regf_mem[`REGF_DISEC_BYTE][3] <= ~hj_enable;    // DISHJ
      regf_mem[zero_addr]           <= '0;
    end
  end

endmodule

//--- i3c_regf_access.sv
//////////////////////////////
// I3C register file access stage
// Turns the host rd/wr strobes into one opcode and
// registers it with the address and write byte
//////////////////////////////
`timescale 1ns/1ps

`include "i3c_regf_params.svh"

module i3c_regf_access
  import i3c_regf_pkg::*;
(
  input  logic                   i_regf_clk,      // Controller clock
  input  logic                   i_regf_rst_n,    // Async, active low
  input  logic                   i_regf_rd_en,    // Read strobe, one cycle
  input  logic                   i_regf_wr_en,    // Write strobe, one cycle
  input  logic [`REGF_ADDR-1:0]  i_regf_addr,
  input  logic [`REGF_WIDTH-1:0] i_regf_data_wr,
  output regf_req_t              o_req            // To the store
);

  regf_op_e               op_d;
  regf_op_e               op_q;
  logic [`REGF_ADDR-1:0]  addr_q;
  logic [`REGF_WIDTH-1:0] wdata_q;

  // Strobe decode, rd and wr together is never a legal access
  always_comb
  begin
    case ({i_regf_wr_en, i_regf_rd_en})
      2'b01:   op_d = OP_READ;
      2'b10:   op_d = OP_WRITE;
      2'b11:   op_d = OP_CONFLICT;
      default: op_d = OP_IDLE;
    endcase
  end

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      op_q <= OP_IDLE;
    end
    else
    begin
      op_q <= op_d;     // Strobes are pulses, so this drops back to IDLE
    end
  end

  // Payload only matters while op_q is READ or WRITE
  always_ff @(posedge i_regf_clk)
  begin
    addr_q  <= i_regf_addr;
    wdata_q <= i_regf_data_wr;
  end

  assign o_req = '{op: op_q, addr: addr_q, wdata: wdata_q};

endmodule

//--- i3c_regf_pkg.sv
//////////////////////////////
// I3C register file types
// Host request, access opcode and the unpacked
// command descriptor
//////////////////////////////

`include "i3c_regf_params.svh"

package i3c_regf_pkg;

  ////////////////////////////// Access opcode

  // Encoded as {wr, rd} so both strobes high land on CONFLICT
  typedef enum logic [1:0] {
    OP_IDLE     = 2'b00,
    OP_READ     = 2'b01,
    OP_WRITE    = 2'b10,
    OP_CONFLICT = 2'b11   // Both strobes at once, store ignores it
  } regf_op_e;

  ////////////////////////////// Host request

  typedef struct packed {
    regf_op_e                 op;     // What the store does this cycle
    logic [`REGF_ADDR-1:0]    addr;   // Byte address
    logic [`REGF_WIDTH-1:0]   wdata;  // Write byte, don't care on reads
  } regf_req_t;

  ////////////////////////////// Command descriptor

  // Field order follows the consumers, not the DWORD bit order
  typedef struct packed {
    logic [15:0] data_len;   // DWORD1 [31:16], to frame counter
    logic [2:0]  cmd_attr;   // DWORD0 [2:0]
    logic [3:0]  tid;        // DWORD0 [6:3], transaction id
    logic [7:0]  ccc_cmd;    // DWORD0 [14:7]
    logic        cp;         // DWORD0 [15], CCC present
    logic [4:0]  dev_index;  // DWORD0 [20:16]
    logic [2:0]  dtt;        // DWORD0 [25:23]
    logic [2:0]  mode;       // DWORD0 [28:26]
    logic        rnw;        // DWORD0 [29]
    logic        wroc;       // DWORD0 [30]
    logic        toc;        // DWORD0 [31], terminate on completion
  } cmd_desc_t;

endpackage

//--- i3c_regf_params.svh
//////////////////////////////
// I3C register file parameters
// Widths, depth and the byte address map of the
// controller configuration store
//////////////////////////////
`ifndef I3C_REGF_PARAMS_SVH
`define I3C_REGF_PARAMS_SVH

////////////////////////////// Sizes

`define REGF_WIDTH          8     // Bits per byte register
`define REGF_DEPTH          512   // Covers every mapped address
`define REGF_ADDR           9     // Byte address bits

////////////////////////////// SDR frame bytes

`define REGF_TGT_ADDR       0     // Target address, bit 0 is RX/TX direction
`define REGF_NUM_FRAMES     1     // Frame count
`define REGF_TGTS_COUNT     35    // Number of targets on the bus

////////////////////////////// Broadcast and IBI bytes

`define REGF_BDCST          46    // 7'h7E with direction bit
`define REGF_ARB            48    // Arbitration address
`define REGF_IBI_CFG        101   // IBI ack and MDB setup
`define REGF_IBI_PAYLOAD    102   // Max IBI payload size

////////////////////////////// Role handoff and hot-join bytes

`define REGF_CRHDLY         383
`define REGF_CRCAP2         386
`define REGF_PRECR          388
`define REGF_GETSTATUS_LSB  390
`define REGF_ENEC_BYTE      402   // Bit 3 is ENHJ
`define REGF_DISEC_BYTE     404   // Bit 3 is DISHJ
`define REGF_HJ_CFG         405   // Hot-join config, bit 1 enables hot-join
`define REGF_CRH_CFG        407
`define REGF_CRCAP1         409   // Bit 0 is hot-join support

////////////////////////////// Command descriptors

`define REGF_DESC_NORMAL    416   // 8 bytes, LSB first
`define REGF_DESC_DUMMY     450   // Fixed dummy command, loaded on reset

`endif
